// ==== hw/rv32i_types.sv ====
`default_nettype none

package rv32i_types;

    // ==================================================
    // Widths
    // ==================================================

    localparam int ARCH_REG_W    = 5;
    localparam int PREG_W        = 6;
    localparam int NUM_ARCH_REGS = 32;

    // ==================================================
    // RV32I major opcodes that carry register fields
    // ==================================================

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // ==================================================
    // Types
    // ==================================================

    // Queue contents at reset
    typedef enum logic {
        ZERO,
        FREE_LIST
    } initialization_t;

    typedef logic [ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [PREG_W-1:0]     preg_t;

    // Instruction with its architectural register fields
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        arch_reg_t   rd;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
    } inst_entry_t;

    // Instruction after renaming, old_pd goes back to the free list at commit
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        preg_t       pd;
        preg_t       ps1;
        preg_t       ps2;
        preg_t       old_pd;
    } renamed_t;

endpackage

`default_nettype wire

// ==== hw/circular_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module circular_queue #(
    parameter type QUEUE_TYPE = rv32i_types::preg_t,
    parameter rv32i_types::initialization_t INIT_TYPE = rv32i_types::ZERO,
    parameter int SS = 2,
    parameter int DEPTH = 8
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic push,
    input  wire logic pop,
    input  QUEUE_TYPE in [SS],
    output logic      empty,
    output logic      full,
    output QUEUE_TYPE out [SS]
);

    localparam int IW    = $clog2(DEPTH);
    localparam int PTR_W = IW + 1;

    QUEUE_TYPE entries [DEPTH];

    // The extra top bit flips on every wrap, so equal indices mean
    // empty when the top bits agree and full when they differ
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;

    logic [IW-1:0] wr_idx [SS];
    logic [IW-1:0] rd_idx [SS];

    // Entry i of the free list holds the value i
    function automatic QUEUE_TYPE index_value(input int i);
        logic [$bits(QUEUE_TYPE)-1:0] v;
        v = $bits(QUEUE_TYPE)'(i);
        return QUEUE_TYPE'(v);
    endfunction

    assign empty = (head == tail);
    assign full  = (head[IW-1:0] == tail[IW-1:0]) && (head[IW] != tail[IW]);

    // Slot addresses wrap naturally since DEPTH is a power of two
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            wr_idx[i] = head[IW-1:0] + IW'(i);
            rd_idx[i] = tail[IW-1:0] + IW'(i);
        end
    end

    // ==================================================
    // Pointers and storage
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
            if (INIT_TYPE == rv32i_types::FREE_LIST) begin
                // Start full with every index available
                head <= PTR_W'(DEPTH);
                for (int i = 0; i < DEPTH; i++) begin
                    entries[i] <= index_value(i);
                end
            end else begin
                head <= '0;
                for (int i = 0; i < DEPTH; i++) begin
                    entries[i] <= '0;
                end
            end
        end else begin
            if (push) begin
                head <= head + PTR_W'(SS);
                for (int i = 0; i < SS; i++) begin
                    entries[wr_idx[i]] <= in[i];
                end
            end
            if (pop) begin
                tail <= tail + PTR_W'(SS);
                for (int i = 0; i < SS; i++) begin
                    out[i] <= entries[rd_idx[i]];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/fetch_intake.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_intake #(
    parameter int SS = 2
) (
    input  wire logic               fetch_valid,
    input  wire logic [31:0]        fetch_pc,
    input  wire logic [31:0]        fetch_inst0,
    input  wire logic [31:0]        fetch_inst1,
    input  wire logic               iq_full,
    output logic                    fetch_ready,
    output logic                    iq_push,
    output rv32i_types::inst_entry_t iq_in [SS]
);

    logic [31:0] inst_w [SS];

    // Pull rd, rs1 and rs2 out according to the instruction format.
    // Fields the format does not have read as x0
    function automatic rv32i_types::inst_entry_t extract(
        input logic [31:0] pc,
        input logic [31:0] inst
    );
        rv32i_types::inst_entry_t e;
        logic has_rd;
        logic has_rs1;
        logic has_rs2;
        has_rd  = 1'b0;
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        case (inst[6:0])
            rv32i_types::OP_REG: begin
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
            end
            rv32i_types::OP_IMM, rv32i_types::OP_LOAD, rv32i_types::OP_JALR: begin
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
            end
            rv32i_types::OP_STORE, rv32i_types::OP_BRANCH: begin
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
            end
            rv32i_types::OP_LUI, rv32i_types::OP_AUIPC, rv32i_types::OP_JAL: begin
                has_rd = 1'b1;
            end
            default: ;
        endcase
        e.pc   = pc;
        e.inst = inst;
        e.rd   = has_rd  ? inst[11:7]  : '0;
        e.rs1  = has_rs1 ? inst[19:15] : '0;
        e.rs2  = has_rs2 ? inst[24:20] : '0;
        return e;
    endfunction

    assign inst_w[0] = fetch_inst0;
    assign inst_w[1] = fetch_inst1;

    // A fetch handshake is a push on the same edge
    assign fetch_ready = !iq_full;
    assign iq_push     = fetch_valid && !iq_full;

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            iq_in[i] = extract(fetch_pc + 32'(4 * i), inst_w[i]);
        end
    end

endmodule

`default_nettype wire

// ==== hw/register_rename.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_rename #(
    parameter int SS = 2
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                iq_empty,
    input  wire logic                fl_empty,
    input  rv32i_types::inst_entry_t iq_out [SS],
    input  rv32i_types::preg_t       fl_out [SS],
    input  wire logic [1:0]          slots_free,
    output logic                     pop,
    output logic                     wr_valid,
    output rv32i_types::renamed_t    wr_data [SS]
);

    // Architectural to physical map
    rv32i_types::preg_t rat [rv32i_types::NUM_ARCH_REGS];

    // High in the cycle after a pop, while its pair sits on the queue outputs
    logic       pop_vld;
    logic [1:0] in_flight;

    // ==================================================
    // Pop control
    // ==================================================

    // A pop already in flight has claimed a buffer slot that slots_free
    // does not show yet
    assign in_flight = {1'b0, pop_vld};
    assign pop       = !iq_empty && !fl_empty && (slots_free > in_flight);

    always_ff @(posedge clk) begin
        if (rst) begin
            pop_vld <= 1'b0;
        end else begin
            pop_vld <= pop;
        end
    end

    // ==================================================
    // Rename
    // ==================================================

    // Each source reads the RAT unless an earlier instruction of the same
    // pair writes that register, in which case the newest such pd wins
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            wr_data[i].pc     = iq_out[i].pc;
            wr_data[i].inst   = iq_out[i].inst;
            wr_data[i].pd     = fl_out[i];
            wr_data[i].ps1    = rat[iq_out[i].rs1];
            wr_data[i].ps2    = rat[iq_out[i].rs2];
            wr_data[i].old_pd = rat[iq_out[i].rd];
            for (int j = 0; j < i; j++) begin
                if (iq_out[i].rs1 == iq_out[j].rd) begin
                    wr_data[i].ps1 = fl_out[j];
                end
                if (iq_out[i].rs2 == iq_out[j].rd) begin
                    wr_data[i].ps2 = fl_out[j];
                end
                if (iq_out[i].rd == iq_out[j].rd) begin
                    wr_data[i].old_pd = fl_out[j];
                end
            end
        end
    end

    assign wr_valid = pop_vld;

    // RAT starts with r mapped to r + 32, the registers outside the free list.
    // Writes go in program order so the later instruction wins
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < rv32i_types::NUM_ARCH_REGS; r++) begin
                rat[r] <= rv32i_types::preg_t'(r + rv32i_types::NUM_ARCH_REGS);
            end
        end else if (pop_vld) begin
            for (int i = 0; i < SS; i++) begin
                rat[iq_out[i].rd] <= fl_out[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/dispatch_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module dispatch_buffer #(
    parameter int SS = 2
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             wr_valid,
    input  rv32i_types::renamed_t wr_data [SS],
    input  wire logic             disp_ready,
    output logic [1:0]            slots_free,
    output logic                  disp_valid,
    output rv32i_types::renamed_t disp_data0,
    output rv32i_types::renamed_t disp_data1
);

    localparam int SLOTS = 2;

    rv32i_types::renamed_t slots [SLOTS][SS];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       rd_en;

    assign disp_valid = (count != 2'd0);
    assign rd_en      = disp_valid && disp_ready;
    assign slots_free = 2'(SLOTS) - count;
    assign disp_data0 = slots[rd_ptr][0];
    assign disp_data1 = slots[rd_ptr][1];

    // The rename credit guarantees room for every write
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (wr_valid) wr_ptr <= !wr_ptr;
            if (rd_en) rd_ptr <= !rd_ptr;
            count <= count + {1'b0, wr_valid} - {1'b0, rd_en};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            for (int i = 0; i < SS; i++) begin
                slots[wr_ptr][i] <= wr_data[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rename_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_top #(
    parameter int SS       = 2,
    parameter int IQ_DEPTH = 8,
    parameter int FL_DEPTH = 32
) (
    input  wire logic             clk,
    input  wire logic             rst,

    // Fetch
    input  wire logic             fetch_valid,
    output logic                  fetch_ready,
    input  wire logic [31:0]      fetch_pc,
    input  wire logic [31:0]      fetch_inst0,
    input  wire logic [31:0]      fetch_inst1,

    // Dispatch
    output logic                  disp_valid,
    input  wire logic             disp_ready,
    output rv32i_types::renamed_t disp_data0,
    output rv32i_types::renamed_t disp_data1,

    // Commit returns old mappings to the free list
    input  wire logic             commit_valid,
    output logic                  commit_ready,
    input  rv32i_types::preg_t    commit_preg0,
    input  rv32i_types::preg_t    commit_preg1
);

    logic                     iq_push;
    logic                     iq_full;
    logic                     iq_empty;
    rv32i_types::inst_entry_t iq_in  [SS];
    rv32i_types::inst_entry_t iq_out [SS];

    logic                     fl_push;
    logic                     fl_full;
    logic                     fl_empty;
    rv32i_types::preg_t       fl_in  [SS];
    rv32i_types::preg_t       fl_out [SS];

    // One pop drains both queues together
    logic                     pop;
    logic                     wr_valid;
    rv32i_types::renamed_t    wr_data [SS];
    logic [1:0]               slots_free;

    // ==================================================
    // Front end and instruction queue
    // ==================================================

    fetch_intake #(
        .SS(SS)
    ) u_intake (
        .fetch_valid(fetch_valid),
        .fetch_pc   (fetch_pc),
        .fetch_inst0(fetch_inst0),
        .fetch_inst1(fetch_inst1),
        .iq_full    (iq_full),
        .fetch_ready(fetch_ready),
        .iq_push    (iq_push),
        .iq_in      (iq_in)
    );

    circular_queue #(
        .QUEUE_TYPE(rv32i_types::inst_entry_t),
        .INIT_TYPE (rv32i_types::ZERO),
        .SS        (SS),
        .DEPTH     (IQ_DEPTH)
    ) u_inst_queue (
        .clk  (clk),
        .rst  (rst),
        .push (iq_push),
        .pop  (pop),
        .in   (iq_in),
        .empty(iq_empty),
        .full (iq_full),
        .out  (iq_out)
    );

    // ==================================================
    // Free list, fed by commit
    // ==================================================

    assign commit_ready = !fl_full;
    assign fl_push      = commit_valid && !fl_full;
    assign fl_in[0]     = commit_preg0;
    assign fl_in[1]     = commit_preg1;

    circular_queue #(
        .QUEUE_TYPE(rv32i_types::preg_t),
        .INIT_TYPE (rv32i_types::FREE_LIST),
        .SS        (SS),
        .DEPTH     (FL_DEPTH)
    ) u_free_list (
        .clk  (clk),
        .rst  (rst),
        .push (fl_push),
        .pop  (pop),
        .in   (fl_in),
        .empty(fl_empty),
        .full (fl_full),
        .out  (fl_out)
    );

    // ==================================================
    // Rename and dispatch
    // ==================================================

    register_rename #(
        .SS(SS)
    ) u_rename (
        .clk       (clk),
        .rst       (rst),
        .iq_empty  (iq_empty),
        .fl_empty  (fl_empty),
        .iq_out    (iq_out),
        .fl_out    (fl_out),
        .slots_free(slots_free),
        .pop       (pop),
        .wr_valid  (wr_valid),
        .wr_data   (wr_data)
    );

    dispatch_buffer #(
        .SS(SS)
    ) u_disp_buf (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .wr_data   (wr_data),
        .disp_ready(disp_ready),
        .slots_free(slots_free),
        .disp_valid(disp_valid),
        .disp_data0(disp_data0),
        .disp_data1(disp_data1)
    );

endmodule

`default_nettype wire

// ==== tb/rename_ref.svh ====
`ifndef RENAME_REF_SVH
`define RENAME_REF_SVH

// ==================================================
// Reference RAT and free list
// ==================================================

rv32i_types::preg_t ref_rat [rv32i_types::NUM_ARCH_REGS];
rv32i_types::preg_t ref_fl [$];

// Same starting point as the hardware, with r mapped to r + 32 and 0 to 31 free
task automatic reset_model();
    ref_fl.delete();
    for (int p = 0; p < FL_DEPTH; p++) begin
        ref_fl.push_back(rv32i_types::preg_t'(p));
    end
    for (int r = 0; r < rv32i_types::NUM_ARCH_REGS; r++) begin
        ref_rat[r] = rv32i_types::preg_t'(r + FL_DEPTH);
    end
endtask

// Register fields that an RV32I format lacks read as x0
task automatic extract_fields(
    input  logic [31:0]            inst,
    output rv32i_types::arch_reg_t rd,
    output rv32i_types::arch_reg_t rs1,
    output rv32i_types::arch_reg_t rs2
);
    rd  = '0;
    rs1 = '0;
    rs2 = '0;
    case (inst[6:0])
        7'b0110011: begin
            rd  = inst[11:7];
            rs1 = inst[19:15];
            rs2 = inst[24:20];
        end
        7'b0010011, 7'b0000011, 7'b1100111: begin
            rd  = inst[11:7];
            rs1 = inst[19:15];
        end
        7'b0100011, 7'b1100011: begin
            rs1 = inst[19:15];
            rs2 = inst[24:20];
        end
        7'b0110111, 7'b0010111, 7'b1101111: rd = inst[11:7];
        default: ;
    endcase
endtask

// Rename one fetched pair in program order; ok is low when no registers are left
task automatic rename_pair(
    input  logic [31:0]           pc,
    input  logic [31:0]           inst0,
    input  logic [31:0]           inst1,
    output rv32i_types::renamed_t e0,
    output rv32i_types::renamed_t e1,
    output logic                  ok
);
    rv32i_types::arch_reg_t rd0;
    rv32i_types::arch_reg_t rs10;
    rv32i_types::arch_reg_t rs20;
    rv32i_types::arch_reg_t rd1;
    rv32i_types::arch_reg_t rs11;
    rv32i_types::arch_reg_t rs21;
    rv32i_types::preg_t     pd0;
    rv32i_types::preg_t     pd1;
    ok = (ref_fl.size() >= 2);
    e0 = '0;
    e1 = '0;
    if (ok) begin
        extract_fields(inst0, rd0, rs10, rs20);
        extract_fields(inst1, rd1, rs11, rs21);
        pd0 = ref_fl.pop_front();
        pd1 = ref_fl.pop_front();
        e0.pc     = pc;
        e0.inst   = inst0;
        e0.pd     = pd0;
        e0.ps1    = ref_rat[rs10];
        e0.ps2    = ref_rat[rs20];
        e0.old_pd = ref_rat[rd0];
        // The second instruction sees the first one's new mapping
        e1.pc     = pc + 32'd4;
        e1.inst   = inst1;
        e1.pd     = pd1;
        e1.ps1    = (rs11 == rd0) ? pd0 : ref_rat[rs11];
        e1.ps2    = (rs21 == rd0) ? pd0 : ref_rat[rs21];
        e1.old_pd = (rd1 == rd0) ? pd0 : ref_rat[rd1];
        ref_rat[rd0] = pd0;
        ref_rat[rd1] = pd1;
    end
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

`endif

// ==== tb/rename_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_tb;

    localparam int SS       = 2;
    localparam int IQ_DEPTH = 8;
    localparam int FL_DEPTH = 32;
    localparam int TIMEOUT  = 2000;

    logic                  clk;
    logic                  rst;
    logic                  fetch_valid;
    logic                  fetch_ready;
    logic [31:0]           fetch_pc;
    logic [31:0]           fetch_inst0;
    logic [31:0]           fetch_inst1;
    logic                  disp_valid;
    logic                  disp_ready;
    rv32i_types::renamed_t disp_data0;
    rv32i_types::renamed_t disp_data1;
    logic                  commit_valid;
    logic                  commit_ready;
    rv32i_types::preg_t    commit_preg0;
    rv32i_types::preg_t    commit_preg1;

    integer seed;
    integer ready_seed;
    int     mismatch_count;
    int     fault_count;
    int     disp_count;
    int     sent_count;
    logic   commit_en;
    logic   ready_random;
    logic   disp_hold;
    logic [31:0] next_pc;

    // Accepted fetch pairs as {pc, inst0, inst1}, and old mappings awaiting commit
    logic [95:0]        fetched_q [$];
    rv32i_types::preg_t commit_q [$];

    `include "rename_ref.svh"

    rename_top #(
        .SS      (SS),
        .IQ_DEPTH(IQ_DEPTH),
        .FL_DEPTH(FL_DEPTH)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_pc    (fetch_pc),
        .fetch_inst0 (fetch_inst0),
        .fetch_inst1 (fetch_inst1),
        .disp_valid  (disp_valid),
        .disp_ready  (disp_ready),
        .disp_data0  (disp_data0),
        .disp_data1  (disp_data1),
        .commit_valid(commit_valid),
        .commit_ready(commit_ready),
        .commit_preg0(commit_preg0),
        .commit_preg1(commit_preg1)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // Random R, I, S or B instruction. Registers mostly come from x0 to x7
    // so pairs often depend on each other
    task automatic make_inst(output logic [31:0] inst);
        logic [31:0] r;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r   = $random(seed);
        imm = $random(seed);
        rd  = r[31] ? r[4:0] : {2'b00, r[2:0]};
        rs1 = r[31] ? r[9:5] : {2'b00, r[7:5]};
        rs2 = r[31] ? r[14:10] : {2'b00, r[12:10]};
        case (r[16:15])
            2'd0: inst = {1'b0, r[17], 5'b0, rs2, rs1, imm[2:0], rd, 7'b0110011};
            2'd1: inst = {imm[11:0], rs1, imm[14:12], rd, 7'b0010011};
            2'd2: inst = {imm[6:0], rs2, rs1, 3'b010, imm[11:7], 7'b0100011};
            default: inst = {imm[6:0], rs2, rs1, 3'b000, imm[11:7], 7'b1100011};
        endcase
    endtask

    task automatic send_pairs(input int n);
        logic [31:0] i0;
        logic [31:0] i1;
        int          waited;
        @(posedge clk);
        for (int k = 0; k < n; k++) begin
            make_inst(i0);
            make_inst(i1);
            fetch_valid <= 1'b1;
            fetch_pc    <= next_pc;
            fetch_inst0 <= i0;
            fetch_inst1 <= i1;
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!fetch_ready && waited < TIMEOUT);
            if (fetch_ready) begin
                fetched_q.push_back({next_pc, i0, i1});
                sent_count++;
            end else begin
                fault_count++;
                $display("Timeout waiting for fetch_ready, pair at pc 0x%h dropped", next_pc);
            end
            next_pc = next_pc + 32'd8;
            @(posedge clk);
        end
        fetch_valid <= 1'b0;
    endtask

    task automatic wait_dispatched(input int target);
        int waited;
        waited = 0;
        while (disp_count < target && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (disp_count < target) begin
            fault_count++;
            $display("Timeout with only %0d of %0d pairs dispatched", disp_count, target);
        end
    endtask

    task automatic compare_pair(
        input int                    slot,
        input rv32i_types::renamed_t got,
        input rv32i_types::renamed_t exp
    );
        check_value($sformatf("disp_data%0d.pc", slot), got.pc, exp.pc);
        check_value($sformatf("disp_data%0d.inst", slot), got.inst, exp.inst);
        check_value($sformatf("disp_data%0d.pd", slot), 32'(got.pd), 32'(exp.pd));
        check_value($sformatf("disp_data%0d.ps1", slot), 32'(got.ps1), 32'(exp.ps1));
        check_value($sformatf("disp_data%0d.ps2", slot), 32'(got.ps2), 32'(exp.ps2));
        check_value($sformatf("disp_data%0d.old_pd", slot), 32'(got.old_pd), 32'(exp.old_pd));
    endtask

    // ==================================================
    // Background drivers and comparison
    // ==================================================

    initial begin : ready_driver
        logic [31:0] r;
        forever begin
            @(posedge clk);
            r = $random(ready_seed);
            if (rst || disp_hold) begin
                disp_ready <= 1'b0;
            end else begin
                disp_ready <= ready_random ? (r[0] | r[1]) : 1'b1;
            end
        end
    end

    // Old mappings go back in dispatch order, one pair per handshake
    initial begin : commit_driver
        int waited;
        forever begin
            @(posedge clk);
            if (commit_en && commit_q.size() >= 2) begin
                commit_valid <= 1'b1;
                commit_preg0 <= commit_q[0];
                commit_preg1 <= commit_q[1];
                waited = 0;
                do begin
                    @(negedge clk);
                    waited++;
                end while (!commit_ready && waited < TIMEOUT);
                if (commit_ready) begin
                    ref_fl.push_back(commit_q.pop_front());
                    ref_fl.push_back(commit_q.pop_front());
                end else begin
                    fault_count++;
                    commit_en = 1'b0;
                    $display("Timeout waiting for commit_ready, commits stopped");
                end
                @(posedge clk);
                commit_valid <= 1'b0;
            end
        end
    end

    initial begin : compare_proc
        logic [95:0]           f;
        rv32i_types::renamed_t exp0;
        rv32i_types::renamed_t exp1;
        logic                  ok;
        forever begin
            @(negedge clk);
            if (!rst && disp_valid && disp_ready) begin
                if (fetched_q.size() == 0) begin
                    fault_count++;
                    $display("A pair was dispatched that fetch never delivered");
                end else begin
                    f = fetched_q.pop_front();
                    rename_pair(f[95:64], f[63:32], f[31:0], exp0, exp1, ok);
                    if (!ok) begin
                        fault_count++;
                        $display("The DUT renamed a pair with no free registers left");
                    end else begin
                        compare_pair(0, disp_data0, exp0);
                        compare_pair(1, disp_data1, exp1);
                        commit_q.push_back(exp0.old_pd);
                        commit_q.push_back(exp1.old_pd);
                    end
                    // First pair after reset takes the bottom of the free list
                    if (disp_count == 0) begin
                        check_value("disp_data0.pd", 32'(disp_data0.pd), 32'd0);
                        check_value("disp_data1.pd", 32'(disp_data1.pd), 32'd1);
                    end
                end
                disp_count++;
            end
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin : main_seq
        int waited;
        seed           = 36163;
        ready_seed     = seed;
        mismatch_count = 0;
        fault_count    = 0;
        disp_count     = 0;
        sent_count     = 0;
        next_pc        = 32'h0000_1000;
        commit_en      = 1'b0;
        ready_random   = 1'b0;
        disp_hold      = 1'b0;
        rst            = 1'b1;
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        fetch_inst0    = '0;
        fetch_inst1    = '0;
        disp_ready     = 1'b0;
        commit_valid   = 1'b0;
        commit_preg0   = '0;
        commit_preg1   = '0;
        reset_model();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("disp_valid", disp_valid, 0);
        check_value("fetch_ready", fetch_ready, 1);
        check_value("commit_ready", commit_ready, 0);

        // Commits withheld, so 16 pairs drain the free list and 4 fill the queue
        send_pairs(20);
        wait_dispatched(16);
        repeat (20) @(posedge clk);
        if (disp_count != 16) begin
            fault_count++;
            $display("Expected dispatch to stop at 16 pairs, saw %0d", disp_count);
        end
        @(negedge clk);
        check_value("fetch_ready", fetch_ready, 0);
        check_value("disp_valid", disp_valid, 0);
        commit_en = 1'b1;
        wait_dispatched(sent_count);

        // Random traffic with random dispatch back-pressure
        @(negedge clk);
        ready_random = 1'b1;
        send_pairs(40);
        wait_dispatched(sent_count);

        // Dispatch held until the queues back up into fetch
        @(negedge clk);
        disp_hold = 1'b1;
        @(negedge clk);
        fork
            send_pairs(12);
            begin
                waited = 0;
                while (!(fetch_valid && !fetch_ready) && waited < TIMEOUT) begin
                    @(negedge clk);
                    waited++;
                end
                if (!(fetch_valid && !fetch_ready)) begin
                    fault_count++;
                    $display("fetch_ready never fell while dispatch was held");
                end
                repeat (4) @(negedge clk);
                // The buffer keeps its renamed pairs while dispatch is held
                check_value("disp_valid", disp_valid, 1);
                disp_hold = 1'b0;
            end
        join
        wait_dispatched(sent_count);
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("disp_valid", disp_valid, 0);
        if (fetched_q.size() != 0 || disp_count != sent_count) begin
            fault_count++;
            $display("Accepted %0d pairs but dispatched %0d", sent_count, disp_count);
        end

        $display("Errors: %0d value mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_core.f ====
+incdir+tb
hw/rv32i_types.sv
hw/circular_queue.sv
hw/fetch_intake.sv
hw/register_rename.sv
hw/dispatch_buffer.sv
hw/rename_top.sv
tb/rename_tb.sv
